/* Bender.yml */
package:
  name: rv_core_slice

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - decode/instruction_decoder.sv
      - decode/control_unit.sv
      - execute/execution_unit.sv
      - design/register_file.sv
      - design/result_unit.sv
      - design/rv_core.sv
  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/core_tb.sv

/* common/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Core datapath and address width
`define RV_XLEN      32

// Architectural registers x0 to x31
`define RV_REG_COUNT 32

// Program counter after reset
`define RV_RESET_PC  32'h0000_0000

`endif

/* common/rv_pkg.sv */
`include "rv_config.svh"

package rv_pkg;

    // ------------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------------

    typedef enum logic [6:0] {
        OP     = 7'b0110011,           // Register-register ALU
        OP_IMM = 7'b0010011,           // Register-immediate ALU
        LOAD   = 7'b0000011,           // LW only
        STORE  = 7'b0100011,           // SW only
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        R_TYPE = 3'd0,
        I_TYPE = 3'd1,
        S_TYPE = 3'd2,
        B_TYPE = 3'd3,
        U_TYPE = 3'd4,
        J_TYPE = 3'd5
    } instr_type_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B                         // Operand b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_IMM  = 2'b00,               // Immediate, used by LUI
        WB_LSU  = 2'b01,               // Load data
        WB_ALU  = 2'b10,
        WB_LINK = 2'b11                // Return address pc + 4
    } wb_sel_e;

    // ------------------------------------------------------------------------
    // Stage bundles
    // ------------------------------------------------------------------------

    typedef struct packed {
        opcode_e              opcode;
        logic [2:0]           funct3;
        logic                 funct7_b5;   // Selects SUB and SRA
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        instr_type_e          instr_type;
        logic [`RV_XLEN-1:0]  imm;         // Sign extended
        logic                 known;       // Opcode is supported
    } decoded_s;

    typedef struct packed {
        logic     operand_a_pc;        // Mux1, pc instead of rs1
        logic     operand_b_imm;       // Mux2, immediate instead of rs2
        alu_op_e  alu_op;
        logic     address_from_rs1;    // Address base rs1, else pc
        logic     read_enable_1;
        logic     read_enable_2;
        logic     write_enable;
        logic     lsu_enable;
        logic     lsu_write;
        logic     is_branch;
        logic     is_jump;
        wb_sel_e  wb_sel;
    } ctrl_s;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  alu_result;
        logic [`RV_XLEN-1:0]  target;      // Load/store address or jump target
        logic                 branch_taken;
    } exec_s;

endpackage

/* compile.f */
+incdir+common
+incdir+test
common/rv_pkg.sv
decode/instruction_decoder.sv
decode/control_unit.sv
execute/execution_unit.sv
design/register_file.sv
design/result_unit.sv
design/rv_core.sv
test/core_tb.sv

/* decode/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  rv_pkg::decoded_s  decoded,
    output rv_pkg::ctrl_s     ctrl
);

    // ------------------------------------------------------------------------
    // ALU operation from funct3, funct7 bit 5 only matters for SUB and SRA
    // ------------------------------------------------------------------------
    function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] funct3,
                                                   input logic       funct7_b5,
                                                   input logic       reg_reg);
        rv_pkg::alu_op_e op;
        case (funct3)
            3'b000:  op = (reg_reg && funct7_b5) ? rv_pkg::SUB : rv_pkg::ADD;  // No SUBI
            3'b001:  op = rv_pkg::SLL;
            3'b010:  op = rv_pkg::SLT;
            3'b011:  op = rv_pkg::SLTU;
            3'b100:  op = rv_pkg::XOR;
            3'b101:  op = funct7_b5 ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  op = rv_pkg::OR;
            default: op = rv_pkg::AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl        = '0;                      // Unknown opcode: no write, no memory
        ctrl.alu_op = rv_pkg::ADD;
        ctrl.wb_sel = rv_pkg::WB_ALU;

        if (decoded.known) begin
            // Register file port enables per format
            case (decoded.instr_type)
                rv_pkg::R_TYPE: begin
                    ctrl.read_enable_1 = 1'b1;
                    ctrl.read_enable_2 = 1'b1;
                    ctrl.write_enable  = 1'b1;
                end
                rv_pkg::I_TYPE: begin
                    ctrl.read_enable_1 = 1'b1;
                    ctrl.write_enable  = 1'b1;
                end
                rv_pkg::S_TYPE, rv_pkg::B_TYPE: begin
                    ctrl.read_enable_1 = 1'b1;
                    ctrl.read_enable_2 = 1'b1;
                end
                default: ctrl.write_enable = 1'b1;     // U and J write rd only
            endcase

            // Operand selects, memory access, address base and writeback source
            case (decoded.opcode)
                rv_pkg::OP_IMM: ctrl.operand_b_imm = 1'b1;
                rv_pkg::LOAD: begin
                    ctrl.lsu_enable       = 1'b1;
                    ctrl.address_from_rs1 = 1'b1;
                    ctrl.wb_sel           = rv_pkg::WB_LSU;
                end
                rv_pkg::STORE: begin
                    ctrl.lsu_enable       = 1'b1;
                    ctrl.lsu_write        = 1'b1;
                    ctrl.address_from_rs1 = 1'b1;
                end
                rv_pkg::BRANCH: ctrl.is_branch = 1'b1;  // Target from pc
                rv_pkg::JAL: begin
                    ctrl.is_jump = 1'b1;
                    ctrl.wb_sel  = rv_pkg::WB_LINK;
                end
                rv_pkg::JALR: begin
                    ctrl.is_jump          = 1'b1;
                    ctrl.address_from_rs1 = 1'b1;
                    ctrl.wb_sel           = rv_pkg::WB_LINK;
                end
                rv_pkg::LUI: begin
                    ctrl.operand_b_imm = 1'b1;
                    ctrl.alu_op        = rv_pkg::PASS_B;
                    ctrl.wb_sel        = rv_pkg::WB_IMM;
                end
                rv_pkg::AUIPC: begin
                    ctrl.operand_a_pc  = 1'b1;          // pc + imm through the ALU
                    ctrl.operand_b_imm = 1'b1;
                end
                default: ;                              // OP keeps the defaults
            endcase

            if (decoded.opcode == rv_pkg::OP || decoded.opcode == rv_pkg::OP_IMM)
                ctrl.alu_op = alu_decode(decoded.funct3, decoded.funct7_b5,
                                         decoded.opcode == rv_pkg::OP);
        end
    end

endmodule

/* decode/instruction_decoder.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module instruction_decoder (
    input  logic [31:0]       instr,
    output rv_pkg::decoded_s  decoded
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    // ------------------------------------------------------------------------
    // Immediate formats, all sign extended from bit 31
    // ------------------------------------------------------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decoded            = '0;
        decoded.opcode     = rv_pkg::opcode_e'(instr[6:0]);  // May hold unlisted values
        decoded.rd         = instr[11:7];
        decoded.funct3     = instr[14:12];
        decoded.rs1        = instr[19:15];
        decoded.rs2        = instr[24:20];
        decoded.funct7_b5  = instr[30];
        decoded.known      = 1'b1;
        decoded.instr_type = rv_pkg::I_TYPE;

        // Format from the major opcode
        case (decoded.opcode)
            rv_pkg::OP:                                   decoded.instr_type = rv_pkg::R_TYPE;
            rv_pkg::OP_IMM, rv_pkg::LOAD, rv_pkg::JALR:   decoded.instr_type = rv_pkg::I_TYPE;
            rv_pkg::STORE:                                decoded.instr_type = rv_pkg::S_TYPE;
            rv_pkg::BRANCH:                               decoded.instr_type = rv_pkg::B_TYPE;
            rv_pkg::LUI, rv_pkg::AUIPC:                   decoded.instr_type = rv_pkg::U_TYPE;
            rv_pkg::JAL:                                  decoded.instr_type = rv_pkg::J_TYPE;
            default:                                      decoded.known      = 1'b0;
        endcase

        // Immediate follows the format, R-type has none
        case (decoded.instr_type)
            rv_pkg::I_TYPE: decoded.imm = imm_i;
            rv_pkg::S_TYPE: decoded.imm = imm_s;
            rv_pkg::B_TYPE: decoded.imm = imm_b;
            rv_pkg::U_TYPE: decoded.imm = imm_u;
            rv_pkg::J_TYPE: decoded.imm = imm_j;
            default:        decoded.imm = '0;
        endcase
    end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module register_file (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [$clog2(`RV_REG_COUNT)-1:0] read_address_1,
    input  logic [$clog2(`RV_REG_COUNT)-1:0] read_address_2,
    output logic [`RV_XLEN-1:0]              read_data_1,
    output logic [`RV_XLEN-1:0]              read_data_2,
    input  logic                             write_enable,
    input  logic [$clog2(`RV_REG_COUNT)-1:0] write_address,
    input  logic [`RV_XLEN-1:0]              write_data
);

    logic [`RV_XLEN-1:0] registers [`RV_REG_COUNT];

    // Combinational read, x0 is never written so it stays zero
    assign read_data_1 = registers[read_address_1];
    assign read_data_2 = registers[read_address_2];

    always_ff @(posedge clk) begin
        if (reset) begin
            registers <= '{default: '0};                     // All registers cleared
        end else if (write_enable && write_address != '0) begin
            registers[write_address] <= write_data;
        end
    end

endmodule

/* design/result_unit.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module result_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  rv_pkg::decoded_s     decoded,
    input  rv_pkg::ctrl_s        ctrl,
    input  rv_pkg::exec_s        result,
    input  logic [`RV_XLEN-1:0]  lsu_rdata,
    output logic [`RV_XLEN-1:0]  pc,
    output logic                 rf_write_enable,
    output logic [`RV_XLEN-1:0]  rf_write_data
);

    logic [`RV_XLEN-1:0] pc_plus_4;
    logic [`RV_XLEN-1:0] pc_next;
    logic                redirect;

    assign pc_plus_4 = pc + `RV_XLEN'(4);

    // ------------------------------------------------------------------------
    // Writeback source
    // ------------------------------------------------------------------------
    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::WB_IMM:  rf_write_data = decoded.imm;        // LUI
            rv_pkg::WB_LSU:  rf_write_data = lsu_rdata;          // Same cycle load data
            rv_pkg::WB_ALU:  rf_write_data = result.alu_result;  // AUIPC too
            default:         rf_write_data = pc_plus_4;          // Link address
        endcase
    end

    assign rf_write_enable = instr_valid & ctrl.write_enable;   // Commit only on strobe

    // ------------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------------
    assign redirect = ctrl.is_jump | result.branch_taken;
    assign pc_next  = redirect ? result.target : pc_plus_4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (instr_valid) begin
            pc <= pc_next;                                      // Holds when no strobe
        end
    end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          instr,
    input  logic                 instr_valid,
    input  logic [`RV_XLEN-1:0]  lsu_rdata,
    output logic [`RV_XLEN-1:0]  pc,
    output logic                 lsu_enable,
    output logic                 lsu_write,
    output logic [`RV_XLEN-1:0]  lsu_address,
    output logic [`RV_XLEN-1:0]  lsu_wdata
);

    rv_pkg::decoded_s     decoded;
    rv_pkg::ctrl_s        ctrl;
    rv_pkg::exec_s        exec_result;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic                 rf_write_enable;
    logic [`RV_XLEN-1:0]  rf_write_data;

    // ------------------------------------------------------------------------
    // Load/store port, qualified by the strobe
    // ------------------------------------------------------------------------
    assign lsu_enable  = instr_valid & ctrl.lsu_enable;
    assign lsu_write   = instr_valid & ctrl.lsu_write;
    assign lsu_address = exec_result.target;             // rs1 + imm
    assign lsu_wdata   = rs2_data;

    instruction_decoder u_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    control_unit u_control (
        .decoded (decoded),
        .ctrl    (ctrl)
    );

    execution_unit u_execute (
        .decoded  (decoded),
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (exec_result)
    );

    register_file u_regfile (
        .clk            (clk),
        .reset          (reset),
        .read_address_1 (decoded.rs1),
        .read_address_2 (decoded.rs2),
        .read_data_1    (rs1_data),
        .read_data_2    (rs2_data),
        .write_enable   (rf_write_enable),
        .write_address  (decoded.rd),
        .write_data     (rf_write_data)
    );

    result_unit u_result (
        .clk             (clk),
        .reset           (reset),
        .instr_valid     (instr_valid),
        .decoded         (decoded),
        .ctrl            (ctrl),
        .result          (exec_result),
        .lsu_rdata       (lsu_rdata),
        .pc              (pc),
        .rf_write_enable (rf_write_enable),
        .rf_write_data   (rf_write_data)
    );

endmodule

/* execute/execution_unit.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module execution_unit (
    input  rv_pkg::decoded_s     decoded,
    input  rv_pkg::ctrl_s        ctrl,
    input  logic [`RV_XLEN-1:0]  pc,
    input  logic [`RV_XLEN-1:0]  rs1_data,
    input  logic [`RV_XLEN-1:0]  rs2_data,
    output rv_pkg::exec_s        result
);

    logic [`RV_XLEN-1:0]         rs1_value;
    logic [`RV_XLEN-1:0]         rs2_value;
    logic [`RV_XLEN-1:0]         operand_a;
    logic [`RV_XLEN-1:0]         operand_b;
    logic [$clog2(`RV_XLEN)-1:0] shamt;
    logic [`RV_XLEN-1:0]         address_sum;
    logic                        condition;

    // Unused read ports present zero
    assign rs1_value = ctrl.read_enable_1 ? rs1_data : '0;
    assign rs2_value = ctrl.read_enable_2 ? rs2_data : '0;

    // ------------------------------------------------------------------------
    // Operand multiplexers and ALU
    // ------------------------------------------------------------------------
    assign operand_a = ctrl.operand_a_pc  ? pc          : rs1_value;   // Mux1
    assign operand_b = ctrl.operand_b_imm ? decoded.imm : rs2_value;   // Mux2
    assign shamt     = operand_b[$clog2(`RV_XLEN)-1:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ADD:    result.alu_result = operand_a + operand_b;
            rv_pkg::SUB:    result.alu_result = operand_a - operand_b;
            rv_pkg::SLL:    result.alu_result = operand_a << shamt;
            rv_pkg::SLT:    result.alu_result = {{(`RV_XLEN-1){1'b0}},
                                                 $signed(operand_a) < $signed(operand_b)};
            rv_pkg::SLTU:   result.alu_result = {{(`RV_XLEN-1){1'b0}}, operand_a < operand_b};
            rv_pkg::XOR:    result.alu_result = operand_a ^ operand_b;
            rv_pkg::SRL:    result.alu_result = operand_a >> shamt;
            rv_pkg::SRA:    result.alu_result = $unsigned($signed(operand_a) >>> shamt);
            rv_pkg::OR:     result.alu_result = operand_a | operand_b;
            rv_pkg::AND:    result.alu_result = operand_a & operand_b;
            rv_pkg::PASS_B: result.alu_result = operand_b;
            default:        result.alu_result = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Branch comparator, works on the raw register values
    // ------------------------------------------------------------------------
    always_comb begin
        case (decoded.funct3)
            3'b000:  condition = rs1_value == rs2_value;                    // BEQ
            3'b001:  condition = rs1_value != rs2_value;                    // BNE
            3'b100:  condition = $signed(rs1_value) <  $signed(rs2_value);  // BLT
            3'b101:  condition = $signed(rs1_value) >= $signed(rs2_value);  // BGE
            3'b110:  condition = rs1_value <  rs2_value;                    // BLTU
            3'b111:  condition = rs1_value >= rs2_value;                    // BGEU
            default: condition = 1'b0;
        endcase
    end

    assign result.branch_taken = ctrl.is_branch & condition;

    // Address adder, base is rs1 for memory and JALR, pc otherwise
    assign address_sum   = (ctrl.address_from_rs1 ? rs1_value : pc) + decoded.imm;
    assign result.target = (ctrl.is_jump && ctrl.address_from_rs1)
                         ? {address_sum[`RV_XLEN-1:1], 1'b0}    // JALR clears bit 0
                         : address_sum;

endmodule

/* test/core_tb_table.svh */
// Program run with one row per strobe slot
// Each row gives its name, the instruction word and the pc after the commit edge, then
// the store address and store data for rows that write memory
// copy_row takes a seeded word index in place of the store data
task automatic load_table();
    idle_row("no strobe after reset", s_format(12'h0BC, 5'd1, 5'd0), 32'd0);

    // ------------------------------------------------------------------------
    // Known values made visible by stores
    // ------------------------------------------------------------------------
    plain_row("addi x1", i_format(12'd5, 5'd0, 3'b000, 5'd1, 7'h13), 32'd4);
    plain_row("addi x2", i_format(12'hFFD, 5'd0, 3'b000, 5'd2, 7'h13), 32'd8);      // -3
    plain_row("lui x3", u_format(20'h12345, 5'd3, 7'h37), 32'd12);
    plain_row("addi x3", i_format(12'h678, 5'd3, 3'b000, 5'd3, 7'h13), 32'd16);
    store_row("sw x1", s_format(12'h040, 5'd1, 5'd0), 32'd20, 32'h40, 32'd5);
    store_row("sw x2", s_format(12'h044, 5'd2, 5'd0), 32'd24, 32'h44, 32'hFFFF_FFFD);
    store_row("sw x3", s_format(12'h048, 5'd3, 5'd0), 32'd28, 32'h48, 32'h1234_5678);
    plain_row("addi x0", i_format(12'd7, 5'd1, 3'b000, 5'd0, 7'h13), 32'd32);       // Dropped
    store_row("sw x0", s_format(12'h04C, 5'd0, 5'd0), 32'd36, 32'h4C, 32'd0);
    plain_row("addi x6", i_format(12'h0F0, 5'd0, 3'b000, 5'd6, 7'h13), 32'd40);

    // ------------------------------------------------------------------------
    // Register-register operations
    // ------------------------------------------------------------------------
    plain_row("sub x4", r_format(1'b1, 3'b000, 5'd4, 5'd1, 5'd2), 32'd44);           // 5 - -3
    store_row("sw sub", s_format(12'h050, 5'd4, 5'd0), 32'd48, 32'h50, 32'd8);
    plain_row("and x5", r_format(1'b0, 3'b111, 5'd5, 5'd3, 5'd6), 32'd52);
    store_row("sw and", s_format(12'h054, 5'd5, 5'd0), 32'd56, 32'h54, 32'h70);
    plain_row("or x7", r_format(1'b0, 3'b110, 5'd7, 5'd1, 5'd6), 32'd60);
    store_row("sw or", s_format(12'h058, 5'd7, 5'd0), 32'd64, 32'h58, 32'hF5);
    plain_row("xor x8", r_format(1'b0, 3'b100, 5'd8, 5'd3, 5'd2), 32'd68);
    store_row("sw xor", s_format(12'h05C, 5'd8, 5'd0), 32'd72, 32'h5C, 32'hEDCB_A985);
    plain_row("slt x9", r_format(1'b0, 3'b010, 5'd9, 5'd2, 5'd1), 32'd76);           // Signed
    store_row("sw slt", s_format(12'h060, 5'd9, 5'd0), 32'd80, 32'h60, 32'd1);
    plain_row("sltu x10", r_format(1'b0, 3'b011, 5'd10, 5'd2, 5'd1), 32'd84);
    store_row("sw sltu", s_format(12'h064, 5'd10, 5'd0), 32'd88, 32'h64, 32'd0);
    plain_row("sll x11", r_format(1'b0, 3'b001, 5'd11, 5'd3, 5'd1), 32'd92);         // By 5
    store_row("sw sll", s_format(12'h068, 5'd11, 5'd0), 32'd96, 32'h68, 32'h468A_CF00);
    plain_row("srl x12", r_format(1'b0, 3'b101, 5'd12, 5'd2, 5'd1), 32'd100);
    store_row("sw srl", s_format(12'h06C, 5'd12, 5'd0), 32'd104, 32'h6C, 32'h07FF_FFFF);
    plain_row("sra x13", r_format(1'b1, 3'b101, 5'd13, 5'd2, 5'd1), 32'd108);
    store_row("sw sra", s_format(12'h070, 5'd13, 5'd0), 32'd112, 32'h70, 32'hFFFF_FFFF);

    // ------------------------------------------------------------------------
    // Load, branches, jumps and odd cases
    // ------------------------------------------------------------------------
    plain_row("addi x14", i_format(12'h080, 5'd0, 3'b000, 5'd14, 7'h13), 32'd116);
    plain_row("lw x15", i_format(12'h008, 5'd14, 3'b010, 5'd15, 7'h03), 32'd120);   // Word 34
    copy_row("sw loaded word", s_format(12'h0A0, 5'd15, 5'd0), 32'd124, 32'hA0, 34);
    plain_row("beq taken", b_format(3'b000, 5'd1, 5'd1, 13'd12), 32'd136);
    plain_row("bne not taken", b_format(3'b001, 5'd1, 5'd1, 13'd8), 32'd140);
    plain_row("beq not taken", b_format(3'b000, 5'd1, 5'd2, 13'd8), 32'd144);
    plain_row("bne taken", b_format(3'b001, 5'd1, 5'd2, 13'd16), 32'd160);
    plain_row("jal x17", j_format(21'd32, 5'd17), 32'd192);
    store_row("sw jal link", s_format(12'h0A8, 5'd17, 5'd0), 32'd196, 32'hA8, 32'd164);
    plain_row("addi x18", i_format(12'h120, 5'd0, 3'b000, 5'd18, 7'h13), 32'd200);
    plain_row("jalr x19", i_format(12'h011, 5'd18, 3'b000, 5'd19, 7'h67), 32'h130); // Odd sum
    store_row("sw jalr link", s_format(12'h0AC, 5'd19, 5'd0), 32'h134, 32'hAC, 32'd204);
    plain_row("auipc x20", u_format(20'h00001, 5'd20, 7'h17), 32'h138);
    store_row("sw auipc", s_format(12'h0B0, 5'd20, 5'd0), 32'h13C, 32'hB0, 32'h1134);
    plain_row("unknown opcode", 32'hFFFF_FFFF, 32'h140);                            // rd is x31
    store_row("sw x31", s_format(12'h0B4, 5'd31, 5'd0), 32'h144, 32'hB4, 32'd0);
    idle_row("no strobe holds pc", s_format(12'h0B8, 5'd1, 5'd0), 32'h144);
endtask

/* test/core_tb.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module core_tb;

    localparam int MEM_WORDS     = 64;
    localparam int RESET_TIMEOUT = 20;          // Cycles

    typedef struct {
        string       name;
        logic        valid;                     // Strobe for the slot
        logic [31:0] instr;
        logic [31:0] exp_pc;                    // pc after the commit edge
        logic        store_exp;
        logic [31:0] store_addr;
        logic [31:0] store_data;                // Seed word index when from_mem is set
        logic        from_mem;
    } row_t;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        instr_valid;
    logic [31:0] lsu_rdata;
    logic [31:0] pc;
    logic        lsu_enable;
    logic        lsu_write;
    logic [31:0] lsu_address;
    logic [31:0] lsu_wdata;

    logic [31:0] data_memory [MEM_WORDS];
    logic [31:0] seed_words  [MEM_WORDS];       // Untouched copy of the fill
    logic        store_seen;
    logic [31:0] store_addr_seen;
    logic [31:0] store_data_seen;

    row_t rows [$];
    int   checks;
    int   errors;
    int   timeouts;

    rv_core uut (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .lsu_rdata   (lsu_rdata),
        .pc          (pc),
        .lsu_enable  (lsu_enable),
        .lsu_write   (lsu_write),
        .lsu_address (lsu_address),
        .lsu_wdata   (lsu_wdata)
    );

    always #4 clk = ~clk;                       // 8 ns period

    // ------------------------------------------------------------------------
    // Data memory with same cycle read and stores at the commit edge
    // ------------------------------------------------------------------------
    assign lsu_rdata = data_memory[lsu_address[7:2]];

    always @(posedge clk) begin
        if (reset) begin
            store_seen <= 1'b0;
        end else begin
            store_seen      <= lsu_enable && lsu_write && instr_valid;   // Last commit only
            store_addr_seen <= lsu_address;
            store_data_seen <= lsu_wdata;
            if (lsu_enable && lsu_write && instr_valid)
                data_memory[lsu_address[7:2]] <= lsu_wdata;
        end
    end

    task automatic fill_memory();
        logic [31:0] word;
        for (int i = 0; i < MEM_WORDS; i++) begin
            word            = $urandom();
            data_memory[i] <= word;
            seed_words[i]   = word;
        end
    endtask

    // ------------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------------
    function automatic logic [31:0] r_format(input logic funct7_b5, input logic [2:0] funct3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        return {1'b0, funct7_b5, 5'b0, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] funct3, input logic [4:0] rd,
                                              input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};                // SW
    endfunction

    function automatic logic [31:0] b_format(input logic [2:0] funct3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                              input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] offset, input logic [4:0] rd);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
    endfunction

    // ------------------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------------------
    task automatic add_row(input string name, input logic valid, input logic [31:0] word,
                           input logic [31:0] exp_pc, input logic store_exp,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic from_mem);
        row_t row;
        row = '{name, valid, word, exp_pc, store_exp, addr, data, from_mem};
        rows.push_back(row);
    endtask

    task automatic plain_row(input string name, input logic [31:0] word,
                             input logic [31:0] exp_pc);
        add_row(name, 1'b1, word, exp_pc, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic idle_row(input string name, input logic [31:0] word,
                            input logic [31:0] exp_pc);
        add_row(name, 1'b0, word, exp_pc, 1'b0, '0, '0, 1'b0);          // Strobe low
    endtask

    task automatic store_row(input string name, input logic [31:0] word,
                             input logic [31:0] exp_pc, input logic [31:0] addr,
                             input logic [31:0] data);
        add_row(name, 1'b1, word, exp_pc, 1'b1, addr, data, 1'b0);
    endtask

    task automatic copy_row(input string name, input logic [31:0] word,
                            input logic [31:0] exp_pc, input logic [31:0] addr,
                            input int word_index);
        add_row(name, 1'b1, word, exp_pc, 1'b1, addr, word_index, 1'b1);
    endtask

    `include "core_tb_table.svh"

    // ------------------------------------------------------------------------
    // Checking and the table loop
    // ------------------------------------------------------------------------
    task automatic compare_word(input string test_name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic run_table();
        row_t        row;
        logic [31:0] exp_data;
        foreach (rows[i]) begin
            row         = rows[i];
            instr       = row.instr;                        // 1 ns after the edge
            instr_valid = row.valid;
            if (!row.valid) begin
                #1;
                compare_word(row.name, "lsu_enable", 32'd0, {31'd0, lsu_enable});
            end
            @(posedge clk);
            #1;
            compare_word(row.name, "pc", row.exp_pc, pc);
            compare_word(row.name, "store", {31'd0, row.store_exp}, {31'd0, store_seen});
            if (row.store_exp && store_seen) begin
                exp_data = row.from_mem ? seed_words[row.store_data[5:0]] : row.store_data;
                compare_word(row.name, "store address", row.store_addr, store_addr_seen);
                compare_word(row.name, "store data", exp_data, store_data_seen);
            end
        end
        instr_valid = 1'b0;
    endtask

    task automatic report_results();
        $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
    endtask

    initial begin
        int wait_cycles;
        void'($urandom(59052));                 // Single seed for the memory fill
        clk         = 1'b0;
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        fill_memory();
        load_table();

        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        wait_cycles = 0;
        while (pc !== `RV_RESET_PC && wait_cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (pc !== `RV_RESET_PC) begin
            $display("Timeout: pc did not take its reset value within %0d cycles", RESET_TIMEOUT);
            timeouts++;
        end else begin
            run_table();
        end

        report_results();
        $finish;
    end

endmodule
